//--- files.f
logic/csum_pkg.sv
logic/byte_pair_combiner.sv
logic/frame_sum_accum.sv
logic/result_arbiter.sv
logic/dual_stream_csum.sv
sim/tb_dual_stream_csum.sv

//--- logic/byte_pair_combiner.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte pair combiner.
// Packs a byte stream into 16-bit words, first byte
// in the upper half, pads an odd last byte with a
// zero low half and flags the frame's final word.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module byte_pair_combiner (
    input  logic                        axis_in,    // Clock.
    input  logic                        rst_n,      // Async reset, active low.
    input  logic [csum_pkg::byte_w-1:0] in_data,    // Incoming byte.
    input  logic                        in_vld,     // Byte taken on every edge it is high.
    input  logic                        in_last,    // High with the frame's final byte.
    output logic [csum_pkg::word_w-1:0] word,       // Packed word, registered.
    output logic                        word_vld,   // One cycle per word.
    output logic                        word_last   // Word holds the last byte.
);

    logic                        half;      // High byte held, waiting for its partner.
    logic [csum_pkg::byte_w-1:0] hi_byte;   // Upper half of the word in progress.
    logic                        emit;      // This byte closes a word.

    // A word closes on the second byte of a pair,
    // or on a last byte that has no partner.
    assign emit = in_vld && (half || in_last);

    // Control state.
    always_ff @(posedge axis_in or negedge rst_n) begin
        if (!rst_n) begin
            half      <= 1'b0;
            word_vld  <= 1'b0;
            word_last <= 1'b0;
        end else begin
            word_vld  <= emit;                  // Strobe for exactly one cycle.
            word_last <= emit && in_last;
            if (in_vld) begin
                if (half) begin
                    half <= 1'b0;               // Pair complete.
                end else if (!in_last) begin
                    half <= 1'b1;               // Store as upper half.
                end
                // A lone last byte leaves half low, next frame starts aligned.
            end
        end
    end

    // Payload path.
    always_ff @(posedge axis_in) begin
        if (in_vld && !half) begin
            hi_byte <= in_data;
        end
        if (emit) begin
            if (half) begin
                word <= {hi_byte, in_data};     // Big endian pair.
            end else begin
                // Odd length, last byte high and zero pad low.
                word <= {in_data, {csum_pkg::byte_w{1'b0}}};
            end
        end
    end

endmodule : byte_pair_combiner

//--- logic/csum_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Checksum engine shared constants.
// Byte, word and sum widths plus the lane count
// used by every block of the dual stream engine.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package csum_pkg;

    // Width of one input byte.
    localparam int byte_w = 8;

    // A combined word holds two bytes, first byte on top.
    localparam int word_w = 2 * byte_w;

    // Accumulator and result width, wraps modulo 2^32.
    localparam int sum_w = 32;

    // Peer lanes sharing the result bus.
    localparam int n_lanes = 2;

    // Lane index width on the result bus.
    localparam int lane_w = (n_lanes > 1) ? $clog2(n_lanes) : 1;

endpackage : csum_pkg

// Other widths are derived from byte_w.
// End of package.

//--- logic/dual_stream_csum.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Dual stream checksum engine, top level.
// Two byte lanes, each combined into words and
// summed per frame, share one result bus through
// a round robin arbiter.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module dual_stream_csum (
    input  logic                        axis_in,    // Clock.
    input  logic                        rst_n,      // Async reset, active low.
    input  logic [csum_pkg::byte_w-1:0] in_data_0,
    input  logic [csum_pkg::byte_w-1:0] in_data_1,
    input  logic                        in_vld_0,
    input  logic                        in_vld_1,
    input  logic                        in_last_0,
    input  logic                        in_last_1,
    output logic                        sum_vld,    // Result strobe.
    output logic [csum_pkg::lane_w-1:0] sum_lane,   // Result lane.
    output logic [csum_pkg::sum_w-1:0]  sum         // Result value.
);

    // Lane 0 internals.
    logic [csum_pkg::word_w-1:0] word_0;
    logic                        word_vld_0;
    logic                        word_last_0;
    logic                        done_0;
    logic [csum_pkg::sum_w-1:0]  frame_sum_0;

    // Lane 1 internals.
    logic [csum_pkg::word_w-1:0] word_1;
    logic                        word_vld_1;
    logic                        word_last_1;
    logic                        done_1;
    logic [csum_pkg::sum_w-1:0]  frame_sum_1;

    byte_pair_combiner comb_0_inst (
        .axis_in   (axis_in),       .rst_n     (rst_n),
        .in_data   (in_data_0),     .in_vld    (in_vld_0),
        .in_last   (in_last_0),     .word      (word_0),
        .word_vld  (word_vld_0),    .word_last (word_last_0)
    );

    frame_sum_accum accum_0_inst (
        .axis_in   (axis_in),       .rst_n     (rst_n),
        .word      (word_0),        .word_vld  (word_vld_0),
        .word_last (word_last_0),   .done      (done_0),
        .frame_sum (frame_sum_0)
    );

    byte_pair_combiner comb_1_inst (
        .axis_in   (axis_in),       .rst_n     (rst_n),
        .in_data   (in_data_1),     .in_vld    (in_vld_1),
        .in_last   (in_last_1),     .word      (word_1),
        .word_vld  (word_vld_1),    .word_last (word_last_1)
    );

    frame_sum_accum accum_1_inst (
        .axis_in   (axis_in),       .rst_n     (rst_n),
        .word      (word_1),        .word_vld  (word_vld_1),
        .word_last (word_last_1),   .done      (done_1),
        .frame_sum (frame_sum_1)
    );

    // Shared bus, 3 cycles from last byte, 4 when contested.
    result_arbiter arb_inst (
        .axis_in     (axis_in),     .rst_n       (rst_n),
        .done_0      (done_0),      .done_1      (done_1),
        .frame_sum_0 (frame_sum_0), .frame_sum_1 (frame_sum_1),
        .sum_vld     (sum_vld),     .sum_lane    (sum_lane),
        .sum         (sum)
    );

endmodule : dual_stream_csum

//--- logic/frame_sum_accum.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame sum accumulator.
// Adds the words of one frame into a 32-bit sum
// and pulses done with the final sum once the
// frame's last word has been taken.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module frame_sum_accum (
    input  logic                        axis_in,    // Clock.
    input  logic                        rst_n,      // Async reset, active low.
    input  logic [csum_pkg::word_w-1:0] word,       // Word from the combiner.
    input  logic                        word_vld,   // Word strobe.
    input  logic                        word_last,  // Final word of the frame.
    output logic                        done,       // One cycle per finished frame.
    output logic [csum_pkg::sum_w-1:0]  frame_sum   // Sum of the finished frame.
);

    logic                       trigger;    // Frame closed on the previous edge.
    logic [csum_pkg::sum_w-1:0] acc;        // Running sum.
    logic [csum_pkg::sum_w-1:0] word_ext;   // Zero extended word.
    logic [csum_pkg::sum_w-1:0] acc_next;   // Running sum with this word.

    assign word_ext = {{(csum_pkg::sum_w - csum_pkg::word_w){1'b0}}, word};
    assign acc_next = acc + word_ext;           // Wraps modulo 2^32.

    always_ff @(posedge axis_in or negedge rst_n) begin
        if (!rst_n) begin
            trigger   <= 1'b0;
            acc       <= '0;
            frame_sum <= '0;
        end else begin
            trigger <= word_vld && word_last;
            if (word_vld && word_last) begin
                frame_sum <= acc_next;          // Valid while trigger is high.
            end
            if (trigger) begin
                // Clear, but keep a first word of the next frame.
                acc <= word_vld ? word_ext : '0;
            end else if (word_vld) begin
                acc <= acc_next;
            end
        end
    end

    assign done = trigger;                      // Done is the trigger itself.

endmodule : frame_sum_accum

//--- logic/result_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result arbiter.
// Holds one pending result per lane and hands the
// shared result bus out round robin, one result per
// cycle, lane order kept.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module result_arbiter (
    input  logic                        axis_in,        // Clock.
    input  logic                        rst_n,          // Async reset, active low.
    input  logic                        done_0,         // Lane 0 frame finished.
    input  logic                        done_1,         // Lane 1 frame finished.
    input  logic [csum_pkg::sum_w-1:0]  frame_sum_0,    // Lane 0 frame sum.
    input  logic [csum_pkg::sum_w-1:0]  frame_sum_1,    // Lane 1 frame sum.
    output logic                        sum_vld,        // One cycle per result.
    output logic [csum_pkg::lane_w-1:0] sum_lane,       // Owner of the result.
    output logic [csum_pkg::sum_w-1:0]  sum             // Frame sum.
);

    logic [csum_pkg::n_lanes-1:0] done;         // Done pulses as a vector.
    logic [csum_pkg::sum_w-1:0]   fsum [csum_pkg::n_lanes];
    logic [csum_pkg::n_lanes-1:0] pend;         // Result waiting in held.
    logic [csum_pkg::sum_w-1:0]   held [csum_pkg::n_lanes];
    logic [csum_pkg::n_lanes-1:0] req;          // Lane has something to send.
    logic [csum_pkg::sum_w-1:0]   val  [csum_pkg::n_lanes];
    logic [csum_pkg::n_lanes-1:0] grant;
    logic [csum_pkg::lane_w-1:0]  sel;          // Granted lane index.
    logic [csum_pkg::lane_w-1:0]  last_grant;   // Lane served most recently.

    assign done    = {done_1, done_0};
    assign fsum[0] = frame_sum_0;
    assign fsum[1] = frame_sum_1;

    // A fresh done goes straight out when uncontested.
    always_comb begin
        for (int i = 0; i < csum_pkg::n_lanes; i++) begin
            req[i] = pend[i] || done[i];
            val[i] = pend[i] ? held[i] : fsum[i];   // Older entry first.
        end
    end

    // Both asking, the lane not granted last wins.
    assign grant[1] = req[1] && (!req[0] || (last_grant == '0));
    assign grant[0] = req[0] && !grant[1];

    always_comb begin
        sel = '0;
        for (int i = 0; i < csum_pkg::n_lanes; i++) begin
            if (grant[i]) sel = i[csum_pkg::lane_w-1:0];
        end
    end

    always_ff @(posedge axis_in or negedge rst_n) begin
        if (!rst_n) begin
            pend       <= '0;
            last_grant <= '0;
            sum_vld    <= 1'b0;
            sum_lane   <= '0;
            sum        <= '0;
            for (int i = 0; i < csum_pkg::n_lanes; i++) held[i] <= '0;
        end else begin
            for (int i = 0; i < csum_pkg::n_lanes; i++) begin
                if (grant[i]) begin
                    pend[i] <= pend[i] && done[i];  // Refill when done meets grant.
                end else if (done[i]) begin
                    pend[i] <= 1'b1;                // Park until granted.
                end
                if (done[i]) held[i] <= fsum[i];
            end
            sum_vld <= |req;
            if (|req) begin
                sum_lane   <= sel;
                sum        <= val[sel];
                last_grant <= sel;
            end
        end
    end

endmodule : result_arbiter

//--- sim/tb_dual_stream_csum.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the dual stream checksum engine.
// Applies a table of frame entries on both lanes,
// models the expected word sums and checks value,
// lane, order and latency of every result.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_dual_stream_csum;

    localparam int n_entries = 48;          // Table size.
    localparam int n_fixed   = 13;          // Directed entries, the rest are random.
    localparam int reset_cyc = 16;

    logic        axis_in;
    logic        rst_n;
    logic [7:0]  in_data_0, in_data_1;
    logic        in_vld_0, in_vld_1;
    logic        in_last_0, in_last_1;
    logic        sum_vld;
    logic [0:0]  sum_lane;
    logic [31:0] sum;

    // Stimulus table, one entry per row.
    int len0 [n_entries];                   // Lane 0 frame length, zero is idle.
    int len1 [n_entries];
    int gap  [n_entries];                   // Idle cycles before the entry.
    bit align [n_entries];                  // Both frames end on the same edge.

    logic [31:0] lfsr = 32'h3fe4;           // Byte source state.
    logic [7:0]  bytes0 [$];                // Bytes of the frame in progress.
    logic [7:0]  bytes1 [$];
    logic [31:0] exp_sum0 [$];              // Expected sums, per lane in frame order.
    logic [31:0] exp_sum1 [$];
    int          exp_acc0 [$];              // Edge that took each frame's last byte.
    int          exp_acc1 [$];

    int cyc = 0;
    int limit = 1 << 30;                    // Recomputed once the table is known.
    int n_sent = 0;
    int n_seen = 0;
    int prev_lane = 0;                      // Arbiter starts with lane 0 as last grant.
    int prev_acc = -1;
    int mon_lane, mon_acc, mon_other, mon_delay, mon_want;
    logic [31:0] mon_exp;

    dual_stream_csum i_dut (
        .axis_in   (axis_in),   .rst_n     (rst_n),
        .in_data_0 (in_data_0), .in_data_1 (in_data_1),
        .in_vld_0  (in_vld_0),  .in_vld_1  (in_vld_1),
        .in_last_0 (in_last_0), .in_last_1 (in_last_1),
        .sum_vld   (sum_vld),   .sum_lane  (sum_lane),
        .sum       (sum)
    );

    initial begin
        axis_in = 1'b0;
        forever #2 axis_in = ~axis_in;      // 4 ns period.
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "run stopped");
    endtask

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // Big endian byte pairs, odd tail padded with a zero low byte, sum mod 2^32.
    function automatic logic [31:0] frame_sum(input logic [7:0] b [$]);
        logic [31:0] s;
        logic [7:0]  lo;
        s = '0;
        for (int i = 0; i < b.size(); i += 2) begin
            lo = (i + 1 < b.size()) ? b[i+1] : 8'h00;
            s  = s + {16'h0000, b[i], lo};
        end
        return s;
    endfunction

    task automatic load_entry(input int idx, input int l0, input int l1,
                              input int g, input bit a);
        len0[idx]  = l0;
        len1[idx]  = l1;
        gap[idx]   = g;
        align[idx] = a;
    endtask

    // One cycle of one lane; a byte driven now is taken on the next edge.
    task automatic drive_lane(input int lane, input bit act, input bit last);
        logic [7:0] b;
        b = act ? rand_bits(8) : 8'h00;
        if (lane == 0) begin
            in_vld_0  <= act;
            in_last_0 <= act && last;
            in_data_0 <= b;
            if (act) bytes0.push_back(b);
            if (act && last) begin
                exp_sum0.push_back(frame_sum(bytes0));
                exp_acc0.push_back(cyc + 2);
                bytes0.delete();
                n_sent++;
            end
        end else begin
            in_vld_1  <= act;
            in_last_1 <= act && last;
            in_data_1 <= b;
            if (act) bytes1.push_back(b);
            if (act && last) begin
                exp_sum1.push_back(frame_sum(bytes1));
                exp_acc1.push_back(cyc + 2);
                bytes1.delete();
                n_sent++;
            end
        end
    endtask

    // Cycle count and watchdog.
    always @(posedge axis_in) begin
        cyc <= cyc + 1;
        if (cyc >= limit) stop_run($sformatf("Timeout after %0d cycles", cyc));
    end

    // Result monitor, sampled mid cycle where outputs are stable.
    always @(negedge axis_in) begin
        if (sum_vld) begin
            assert (rst_n) else stop_run("Result strobe seen during reset");
            mon_lane = int'(sum_lane);
            if (mon_lane == 0) begin
                assert (exp_sum0.size() > 0)
                    else stop_run("Lane 0 result with no frame outstanding");
                mon_exp   = exp_sum0.pop_front();
                mon_acc   = exp_acc0.pop_front();
                mon_other = (exp_acc1.size() > 0) ? exp_acc1[0] : -1;
            end else begin
                assert (exp_sum1.size() > 0)
                    else stop_run("Lane 1 result with no frame outstanding");
                mon_exp   = exp_sum1.pop_front();
                mon_acc   = exp_acc1.pop_front();
                mon_other = (exp_acc0.size() > 0) ? exp_acc0[0] : -1;
            end
            assert (sum == mon_exp)
                else stop_run($sformatf("error sum lane %0d: expected %h, got %h",
                                        mon_lane, mon_exp, sum));
            // The strobe is taken on the next edge.
            // Loser of a simultaneous ending follows one cycle behind.
            mon_delay = cyc + 1 - mon_acc;
            mon_want  = (mon_acc == prev_acc && mon_lane != prev_lane) ? 4 : 3;
            assert (mon_delay == mon_want)
                else stop_run($sformatf("Lane %0d result took %0d cycles, expected %0d",
                                        mon_lane, mon_delay, mon_want));
            // Contested winner is the lane not served last.
            if (mon_other == mon_acc) begin
                assert (mon_lane != prev_lane)
                    else stop_run("Round robin did not alternate on a contested pair");
            end
            prev_lane = mon_lane;
            prev_acc  = mon_acc;
            n_seen++;
        end
    end

    initial begin
        int span, off0, off1, sel, total;
        bit act0, act1;
        rst_n     = 1'b0;
        in_data_0 = '0;
        in_data_1 = '0;
        in_vld_0  = 1'b0;
        in_vld_1  = 1'b0;
        in_last_0 = 1'b0;
        in_last_1 = 1'b0;

        load_entry(0,  4, 0, 2, 0);         // Even, lane 0.
        load_entry(1,  0, 6, 3, 0);         // Even, lane 1.
        load_entry(2,  5, 0, 3, 0);         // Odd, padded tail.
        load_entry(3,  0, 3, 3, 0);
        load_entry(4,  2, 0, 4, 0);         // Back to back on lane 0.
        load_entry(5,  3, 0, 0, 0);
        load_entry(6,  4, 0, 0, 0);
        load_entry(7,  0, 2, 4, 0);         // Minimum frames back to back.
        load_entry(8,  0, 2, 0, 0);
        load_entry(9,  4, 4, 5, 1);         // Simultaneous endings.
        load_entry(10, 3, 6, 6, 1);
        load_entry(11, 7, 2, 6, 0);         // Lane 0 ends last and lane 1 wins the next pair.
        load_entry(12, 2, 2, 6, 1);
        for (int e = n_fixed; e < n_entries; e++) begin
            sel = rand_bits(2);
            load_entry(e, rand_bits(3) + 2, rand_bits(3) + 2, rand_bits(2), 1'b0);
            if (sel == 0) len1[e] = 0;
            else if (sel == 1) len0[e] = 0;
            else align[e] = rand_bits(1);
        end
        total = reset_cyc + 20;
        for (int e = 0; e < n_entries; e++) begin
            total += len0[e] + len1[e] + gap[e] + 20;
        end
        limit = total;

        repeat (reset_cyc) @(posedge axis_in);
        rst_n <= 1'b1;

        for (int e = 0; e < n_entries; e++) begin
            repeat (gap[e]) begin
                @(posedge axis_in);
                drive_lane(0, 1'b0, 1'b0);
                drive_lane(1, 1'b0, 1'b0);
            end
            span = (len0[e] > len1[e]) ? len0[e] : len1[e];
            off0 = align[e] ? span - len0[e] : 0;   // Shorter frame starts late.
            off1 = align[e] ? span - len1[e] : 0;
            for (int k = 0; k < span; k++) begin
                act0 = (len0[e] != 0) && (k >= off0) && (k < off0 + len0[e]);
                act1 = (len1[e] != 0) && (k >= off1) && (k < off1 + len1[e]);
                @(posedge axis_in);
                drive_lane(0, act0, k == off0 + len0[e] - 1);
                drive_lane(1, act1, k == off1 + len1[e] - 1);
            end
        end
        @(posedge axis_in);
        drive_lane(0, 1'b0, 1'b0);
        drive_lane(1, 1'b0, 1'b0);

        while (exp_sum0.size() > 0 || exp_sum1.size() > 0) @(posedge axis_in);
        repeat (8) @(posedge axis_in);      // Catch any extra result.

        if (n_seen == n_sent && exp_sum0.size() == 0 && exp_sum1.size() == 0) begin
            $display("No errors");
            $finish;
        end else begin
            stop_run($sformatf("Saw %0d results for %0d frames", n_seen, n_sent));
        end
    end

endmodule : tb_dual_stream_csum
